// File: src/lsq_pkg.sv
////////////////////////////////////////
// Core-side types and sizes for the load/store queue
// Imported by the queues, the dispatch interface and the top
////////////////////////////////////////
`default_nettype none

package lsq_pkg;

	localparam int PRF_SIZE = 64;
	localparam int ROB_SIZE = 32;
	localparam int LQ_SIZE  = 8;
	localparam int SQ_SIZE  = 8;

	typedef logic [63:0]                   word_t;
	typedef logic [$clog2(PRF_SIZE)-1:0]   prf_tag_t;
	typedef logic [$clog2(ROB_SIZE)-1:0]   rob_idx_t;
	typedef logic [5:0]                    op_type_t;
	typedef logic [$clog2(LQ_SIZE)-1:0]    lq_idx_t;
	typedef logic [$clog2(SQ_SIZE)-1:0]    sq_idx_t;
	typedef logic [SQ_SIZE-1:0]            sq_mask_t;

	localparam op_type_t OP_LOAD  = 6'h29;  // LDQ
	localparam op_type_t OP_STORE = 6'h2d;  // STQ

	typedef enum logic [2:0] {
		LQ_FREE, LQ_WAIT_OPERAND, LQ_READY, LQ_REQUESTED, LQ_FILLED
	} lq_state_t;

	typedef enum logic [1:0] {
		SQ_FREE, SQ_WAIT_OPERAND, SQ_READY, SQ_REPORTED
	} sq_state_t;

	// An operand that is not ready carries its awaited tag in the low bits
	function automatic logic awaits_tag(input word_t field, input prf_tag_t tag);
		return field[$bits(prf_tag_t)-1:0] == tag;
	endfunction

endpackage

`default_nettype wire

// File: src/mem_bus_pkg.sv
////////////////////////////////////////
// Data-memory bus commands, tags and payload types
////////////////////////////////////////
`default_nettype none

package mem_bus_pkg;

	localparam int NUM_MEM_TAGS = 16;

	typedef logic [1:0]                        bus_command_t;
	typedef logic [$clog2(NUM_MEM_TAGS)-1:0]   mem_tag_t;  // Zero means no tag
	typedef logic [63:0]                       mem_addr_t;
	typedef logic [63:0]                       mem_data_t;

	localparam bus_command_t BUS_NONE  = 2'd0;
	localparam bus_command_t BUS_LOAD  = 2'd1;
	localparam bus_command_t BUS_STORE = 2'd2;

endpackage

`default_nettype wire

// File: src/lsq_dispatch_if.sv
////////////////////////////////////////
// One decoded memory instruction from the top to both queues
// The top drives every field, each queue reads its own subset
////////////////////////////////////////
`default_nettype none

interface lsq_dispatch_if import lsq_pkg::*; ();

	logic      load_write;        // One-cycle write strobes
	logic      store_write;
	word_t     base;
	word_t     offset;
	logic      offset_ready;      // Low means offset holds a tag
	word_t     store_data;
	logic      store_data_ready;
	rob_idx_t  rob_idx;
	prf_tag_t  dest_tag;

	modport top (
		output load_write, store_write, base, offset, offset_ready,
		output store_data, store_data_ready, rob_idx, dest_tag
	);

	modport lq (
		input load_write, base, offset, offset_ready, rob_idx, dest_tag
	);

	modport sq (
		input store_write, base, offset, offset_ready,
		input store_data, store_data_ready, rob_idx, dest_tag
	);

endinterface

`default_nettype wire

// File: src/mem_req_if.sv
////////////////////////////////////////
// Queue-to-scheduler traffic
// Load candidate, accept and fill on one side, store commit on the other
////////////////////////////////////////
`default_nettype none

interface mem_req_if import lsq_pkg::*, mem_bus_pkg::*; ();

	// Load side
	logic       load_valid;
	lq_idx_t    load_idx;
	mem_addr_t  load_addr;
	logic       accept_valid;
	lq_idx_t    accept_idx;
	logic       fill_valid;
	lq_idx_t    fill_idx;
	mem_data_t  fill_data;

	// Store side
	logic       store_valid;
	mem_addr_t  store_addr;
	mem_data_t  store_data;
	logic       store_done;

	modport lq (
		output load_valid, load_idx, load_addr,
		input  accept_valid, accept_idx, fill_valid, fill_idx, fill_data
	);

	modport sq (
		output store_valid, store_addr, store_data,
		input  store_done
	);

	modport sched (
		input  load_valid, load_idx, load_addr, store_valid, store_addr, store_data,
		output accept_valid, accept_idx, fill_valid, fill_idx, fill_data, store_done
	);

endinterface

`default_nettype wire

// File: src/load_queue.sv
////////////////////////////////////////
// Load entries, filled from the lowest free slot
// Waits on older stores, offers one memory candidate, holds fill data
////////////////////////////////////////
`default_nettype none

module load_queue import lsq_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      mispredict,
	lsq_dispatch_if.lq disp,
	mem_req_if.lq     req,
	input  sq_mask_t  sq_busy,
	input  logic      cdb_valid,
	input  prf_tag_t  cdb_tag,
	input  word_t     cdb_value,
	input  logic      free_load,
	input  lq_idx_t   free_idx,
	output logic      filled,
	output lq_idx_t   filled_idx,
	output word_t     filled_value,
	output rob_idx_t  filled_rob_idx,
	output prf_tag_t  filled_dest_tag,
	output logic      full
);
	lq_state_t  state [LQ_SIZE];
	word_t      base [LQ_SIZE];
	word_t      offset [LQ_SIZE];
	word_t      value [LQ_SIZE];
	rob_idx_t   rob_idx [LQ_SIZE];
	prf_tag_t   dest_tag [LQ_SIZE];
	sq_mask_t   order [LQ_SIZE];  // Older stores not yet written

	logic [LQ_SIZE-1:0] wake;
	lq_idx_t  wr_idx;
	lq_idx_t  cand_idx;
	logic     write;
	logic     offset_ok;
	word_t    offset_in;

	// Result bus bypass at the entry input
	always_comb begin
		offset_ok = disp.offset_ready;
		offset_in = disp.offset;
		if (!disp.offset_ready && cdb_valid && awaits_tag(disp.offset, cdb_tag)) begin
			offset_ok = 1'b1;
			offset_in = cdb_value;
		end
	end

	////////////////////////////////////////
	// Slot search, candidate and fill pick
	////////////////////////////////////////
	always_comb begin
		full = 1'b1;
		wr_idx = '0;
		cand_idx = '0;
		req.load_valid = 1'b0;
		filled = 1'b0;
		filled_idx = '0;
		for (int i = LQ_SIZE - 1; i >= 0; i--) begin  // Lowest index wins
			wake[i] = state[i] == LQ_WAIT_OPERAND && cdb_valid && awaits_tag(offset[i], cdb_tag);
			if (state[i] == LQ_FREE) begin
				full = 1'b0;
				wr_idx = lq_idx_t'(i);
			end
			if (state[i] == LQ_READY && order[i] == '0) begin
				req.load_valid = 1'b1;
				cand_idx = lq_idx_t'(i);
			end
			if (state[i] == LQ_FILLED) begin
				filled = 1'b1;
				filled_idx = lq_idx_t'(i);
			end
		end
	end

	assign write           = disp.load_write && !full;
	assign req.load_idx    = cand_idx;
	assign req.load_addr   = base[cand_idx] + offset[cand_idx];
	assign filled_value    = value[filled_idx];
	assign filled_rob_idx  = rob_idx[filled_idx];
	assign filled_dest_tag = dest_tag[filled_idx];

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			for (int i = 0; i < LQ_SIZE; i++)
				state[i] <= LQ_FREE;
		end else begin
			for (int i = 0; i < LQ_SIZE; i++) begin
				if (write && wr_idx == lq_idx_t'(i))
					state[i] <= offset_ok ? LQ_READY : LQ_WAIT_OPERAND;
				else if (wake[i])
					state[i] <= LQ_READY;
				else if (req.accept_valid && req.accept_idx == lq_idx_t'(i))
					state[i] <= LQ_REQUESTED;
				else if (req.fill_valid && req.fill_idx == lq_idx_t'(i))
					state[i] <= LQ_FILLED;
				else if (free_load && free_idx == lq_idx_t'(i))
					state[i] <= LQ_FREE;
			end
		end
	end

	// Payload, no reset
	always_ff @(posedge clock) begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			order[i] <= order[i] & sq_busy;  // Drop stores as their slots free up
			if (write && wr_idx == lq_idx_t'(i)) begin
				base[i]     <= disp.base;
				offset[i]   <= offset_in;
				rob_idx[i]  <= disp.rob_idx;
				dest_tag[i] <= disp.dest_tag;
				order[i]    <= sq_busy;
			end else if (wake[i]) begin
				offset[i] <= cdb_value;
			end
			if (req.fill_valid && req.fill_idx == lq_idx_t'(i))
				value[i] <= req.fill_data;
		end
	end

endmodule

`default_nettype wire

// File: src/store_queue.sv
////////////////////////////////////////
// Circular store buffer, head reports then commits at ROB head
////////////////////////////////////////
`default_nettype none

module store_queue import lsq_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      mispredict,
	lsq_dispatch_if.sq disp,
	mem_req_if.sq     req,
	input  logic      cdb_valid,
	input  prf_tag_t  cdb_tag,
	input  word_t     cdb_value,
	input  rob_idx_t  rob_head,
	input  logic      report_take,
	output logic      report_valid,
	output rob_idx_t  report_rob_idx,
	output prf_tag_t  report_dest_tag,
	output word_t     report_addr,
	output sq_mask_t  sq_busy,
	output logic      full
);
	sq_state_t  state [SQ_SIZE];
	word_t      base [SQ_SIZE];
	word_t      offset [SQ_SIZE];
	word_t      data [SQ_SIZE];
	rob_idx_t   rob_idx [SQ_SIZE];
	prf_tag_t   dest_tag [SQ_SIZE];
	logic [SQ_SIZE-1:0] addr_ok, data_ok;        // Operand present
	logic [SQ_SIZE-1:0] offset_hit, data_hit;

	sq_idx_t  head, tail;
	logic     write;
	logic     offset_in_ok, data_in_ok;
	word_t    offset_in, data_in;

	// Bypass for both tagged fields at dispatch
	always_comb begin
		offset_in_ok = disp.offset_ready || (cdb_valid && awaits_tag(disp.offset, cdb_tag));
		data_in_ok = disp.store_data_ready || (cdb_valid && awaits_tag(disp.store_data, cdb_tag));
		offset_in = disp.offset_ready ? disp.offset : (offset_in_ok ? cdb_value : disp.offset);
		data_in = disp.store_data_ready ? disp.store_data
			: (data_in_ok ? cdb_value : disp.store_data);
		for (int i = 0; i < SQ_SIZE; i++) begin
			sq_busy[i] = state[i] != SQ_FREE;
			offset_hit[i] = state[i] == SQ_WAIT_OPERAND && !addr_ok[i] && cdb_valid
				&& awaits_tag(offset[i], cdb_tag);
			data_hit[i] = state[i] == SQ_WAIT_OPERAND && !data_ok[i] && cdb_valid
				&& awaits_tag(data[i], cdb_tag);
		end
	end

	assign full  = state[tail] != SQ_FREE;
	assign write = disp.store_write && !full;

	// Head offers the report, then the commit
	assign report_valid    = state[head] == SQ_READY;
	assign report_rob_idx  = rob_idx[head];
	assign report_dest_tag = dest_tag[head];
	assign report_addr     = base[head] + offset[head];
	assign req.store_valid = state[head] == SQ_REPORTED && rob_idx[head] == rob_head;
	assign req.store_addr  = report_addr;
	assign req.store_data  = data[head];

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			head <= '0;
			tail <= '0;
			for (int i = 0; i < SQ_SIZE; i++)
				state[i] <= SQ_FREE;
		end else begin
			if (write)
				tail <= tail + 1'b1;
			if (req.store_done)
				head <= head + 1'b1;
			for (int i = 0; i < SQ_SIZE; i++) begin
				if (write && tail == sq_idx_t'(i))
					state[i] <= (offset_in_ok && data_in_ok) ? SQ_READY : SQ_WAIT_OPERAND;
				else if (state[i] == SQ_WAIT_OPERAND && (addr_ok[i] || offset_hit[i])
						&& (data_ok[i] || data_hit[i]))
					state[i] <= SQ_READY;
				else if (report_take && head == sq_idx_t'(i))
					state[i] <= SQ_REPORTED;
				else if (req.store_done && head == sq_idx_t'(i))
					state[i] <= SQ_FREE;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (write && tail == sq_idx_t'(i)) begin
				base[i]     <= disp.base;
				offset[i]   <= offset_in;
				data[i]     <= data_in;
				addr_ok[i]  <= offset_in_ok;
				data_ok[i]  <= data_in_ok;
				rob_idx[i]  <= disp.rob_idx;
				dest_tag[i] <= disp.dest_tag;
			end else begin
				if (offset_hit[i]) begin
					offset[i]  <= cdb_value;
					addr_ok[i] <= 1'b1;
				end
				if (data_hit[i]) begin
					data[i]    <= cdb_value;
					data_ok[i] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/mem_scheduler.sv
////////////////////////////////////////
// Drives the data-memory bus from the queue requests
// Replays a refused command and routes returned tags to load slots
////////////////////////////////////////
`default_nettype none

module mem_scheduler import lsq_pkg::*, mem_bus_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          mispredict,
	mem_req_if.sched      req,
	output bus_command_t  mem_command,
	output mem_addr_t     mem_address,
	output mem_data_t     mem_data,
	input  mem_tag_t      mem_response,
	input  mem_tag_t      mem_tag,
	input  mem_data_t     mem_data_in
);
	// Refused request, presented again until taken
	logic          held_valid;
	bus_command_t  held_command;
	mem_addr_t     held_addr;
	mem_data_t     held_data;
	lq_idx_t       held_idx;

	logic [NUM_MEM_TAGS-1:0] tag_valid;
	lq_idx_t       tag_slot [NUM_MEM_TAGS];

	lq_idx_t       pick_idx;
	logic          accepted;

	////////////////////////////////////////
	// Request choice
	////////////////////////////////////////
	always_comb begin
		mem_command = BUS_NONE;
		mem_address = '0;
		mem_data = '0;
		pick_idx = '0;
		if (held_valid) begin
			mem_command = held_command;
			mem_address = held_addr;
			mem_data = held_data;
			pick_idx = held_idx;
		end else if (req.store_valid) begin  // Commit beats a load
			mem_command = BUS_STORE;
			mem_address = req.store_addr;
			mem_data = req.store_data;
		end else if (req.load_valid) begin
			mem_command = BUS_LOAD;
			mem_address = req.load_addr;
			pick_idx = req.load_idx;
		end
		accepted = mem_command != BUS_NONE && mem_response != '0;
		req.accept_valid = accepted && mem_command == BUS_LOAD;
		req.accept_idx = pick_idx;
		req.store_done = accepted && mem_command == BUS_STORE;
	end

	always_ff @(posedge clock) begin
		if (reset || mispredict)
			held_valid <= 1'b0;
		else
			held_valid <= mem_command != BUS_NONE && !accepted;
	end

	always_ff @(posedge clock) begin
		if (!held_valid) begin
			held_command <= mem_command;
			held_addr    <= mem_address;
			held_data    <= mem_data;
			held_idx     <= pick_idx;
		end
	end

	////////////////////////////////////////
	// Tag table
	////////////////////////////////////////
	assign req.fill_valid = mem_tag != '0 && tag_valid[mem_tag];
	assign req.fill_idx   = tag_slot[mem_tag];
	assign req.fill_data  = mem_data_in;

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tag_valid <= '0;  // Late fills of flushed loads fall through
		end else begin
			if (req.fill_valid)
				tag_valid[mem_tag] <= 1'b0;
			if (req.accept_valid)
				tag_valid[mem_response] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (req.accept_valid)
			tag_slot[mem_response] <= req.accept_idx;
	end

endmodule

`default_nettype wire

// File: src/lsq.sv
////////////////////////////////////////
// Load/store queue top
// Decodes dispatch, links queues to the memory scheduler, picks the result
////////////////////////////////////////
`default_nettype none

module lsq import lsq_pkg::*, mem_bus_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          inst_valid,
	input  op_type_t      op_type,
	input  word_t         base,
	input  word_t         offset,
	input  logic          offset_ready,
	input  word_t         store_data,
	input  logic          store_data_ready,
	input  rob_idx_t      rob_idx,
	input  prf_tag_t      dest_tag,
	input  logic          cdb_valid,
	input  prf_tag_t      cdb_tag,
	input  word_t         cdb_value,
	input  rob_idx_t      rob_head,
	input  logic          mispredict,
	output bus_command_t  mem_command,
	output mem_addr_t     mem_address,
	output mem_data_t     mem_data,
	input  mem_tag_t      mem_response,
	input  mem_tag_t      mem_tag,
	input  mem_data_t     mem_data_in,
	output logic          result_valid,
	output word_t         result_value,
	output prf_tag_t      result_tag,
	output rob_idx_t      result_rob_idx,
	output logic          lsq_full
);
	lsq_dispatch_if disp ();
	mem_req_if      req ();

	logic      lq_full, sq_full;
	sq_mask_t  sq_busy;
	logic      dispatch_ok;
	logic      free_load, report_take;
	logic      filled;
	lq_idx_t   filled_idx;
	word_t     filled_value;
	rob_idx_t  filled_rob_idx;
	prf_tag_t  filled_dest_tag;
	logic      report_valid;
	rob_idx_t  report_rob_idx;
	prf_tag_t  report_dest_tag;
	word_t     report_addr;

	assign lsq_full    = lq_full || sq_full;
	assign dispatch_ok = inst_valid && !mispredict && !lsq_full;

	assign disp.load_write       = dispatch_ok && op_type == OP_LOAD;
	assign disp.store_write      = dispatch_ok && op_type == OP_STORE;
	assign disp.base             = base;
	assign disp.offset           = offset;
	assign disp.offset_ready     = offset_ready;
	assign disp.store_data       = store_data;
	assign disp.store_data_ready = store_data_ready;
	assign disp.rob_idx          = rob_idx;
	assign disp.dest_tag         = dest_tag;

	// Filled load first, else the store report
	always_comb begin
		free_load = 1'b0;
		report_take = 1'b0;
		result_valid = 1'b0;
		result_value = '0;
		result_tag = '0;
		result_rob_idx = '0;
		if (filled) begin
			free_load = 1'b1;
			result_valid = 1'b1;
			result_value = filled_value;
			result_tag = filled_dest_tag;
			result_rob_idx = filled_rob_idx;
		end else if (report_valid) begin
			report_take = 1'b1;
			result_valid = 1'b1;
			result_value = report_addr;  // Store completes with its address
			result_tag = report_dest_tag;
			result_rob_idx = report_rob_idx;
		end
	end

	load_queue u_load_queue (
		.clock(clock), .reset(reset), .mispredict(mispredict),
		.disp(disp.lq), .req(req.lq), .sq_busy(sq_busy),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.free_load(free_load), .free_idx(filled_idx),
		.filled(filled), .filled_idx(filled_idx), .filled_value(filled_value),
		.filled_rob_idx(filled_rob_idx), .filled_dest_tag(filled_dest_tag),
		.full(lq_full)
	);

	store_queue u_store_queue (
		.clock(clock), .reset(reset), .mispredict(mispredict),
		.disp(disp.sq), .req(req.sq),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.rob_head(rob_head), .report_take(report_take),
		.report_valid(report_valid), .report_rob_idx(report_rob_idx),
		.report_dest_tag(report_dest_tag), .report_addr(report_addr),
		.sq_busy(sq_busy), .full(sq_full)
	);

	mem_scheduler u_mem_scheduler (
		.clock(clock), .reset(reset), .mispredict(mispredict), .req(req.sched),
		.mem_command(mem_command), .mem_address(mem_address), .mem_data(mem_data),
		.mem_response(mem_response), .mem_tag(mem_tag), .mem_data_in(mem_data_in)
	);

endmodule

`default_nettype wire

// File: bench/lsq_tb.sv
////////////////////////////////////////
// Self-checking testbench for the load/store queue
// Tagged memory model, LFSR driven refusals and delays, scoreboard
////////////////////////////////////////
`default_nettype none

module lsq_tb import lsq_pkg::*, mem_bus_pkg::*; ();

	localparam word_t DATA_KEY = 64'h5a5a_c3c3_0f0f_9696;  // Memory returns address ^ key
	localparam int T_RESET = 10;
	localparam int T_LOAD = 300;
	localparam int T_WAKE = 150;
	localparam int T_STORE = 300;
	localparam int T_FULL = 200;
	localparam int WATCHDOG_CYCLES = T_RESET + T_LOAD + T_WAKE + T_STORE + T_FULL + 100;

	logic clock, reset, inst_valid, offset_ready, store_data_ready;
	logic cdb_valid, mispredict, result_valid, lsq_full;
	op_type_t op_type;
	word_t base, offset, store_data, cdb_value, result_value;
	rob_idx_t rob_idx, rob_head, result_rob_idx;
	prf_tag_t dest_tag, cdb_tag, result_tag;
	bus_command_t mem_command;
	mem_addr_t mem_address;
	mem_data_t mem_data, mem_data_in;
	mem_tag_t mem_response, mem_tag;

	// Memory model and scoreboard state
	logic [15:0] mem_lfsr;   // Memory model and monitor draws
	logic [15:0] stim_lfsr;  // Directed sequence draws
	int cycle;
	logic hold_fills;
	mem_tag_t next_tag;
	mem_tag_t pend_tag [$];
	mem_addr_t pend_addr [$];
	int pend_due [$];
	mem_addr_t load_addrs [$];
	logic exp_valid [64];
	word_t exp_value [64];
	rob_idx_t exp_rob [64];
	logic store_pending;
	mem_addr_t store_addr_exp;
	mem_data_t store_data_exp;
	rob_idx_t store_rob_exp;

	lsq u_lsq (.*);

	always #5 clock = ~clock;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int random_bits(inout logic [15:0] state, input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | state[0];
			state = lfsr_next(state);
		end
		return r;
	endfunction

	function automatic logic tag_in_flight(input mem_tag_t t);
		foreach (pend_tag[i])
			if (pend_tag[i] == t)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic int open_results();
		int n;
		n = load_addrs.size() + int'(store_pending);
		for (int i = 0; i < 64; i++)
			n += int'(exp_valid[i]);
		return n;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic expect_load(input prf_tag_t tag, input rob_idx_t rob, input mem_addr_t addr);
		exp_valid[tag] = 1'b1;
		exp_value[tag] = addr ^ DATA_KEY;
		exp_rob[tag] = rob;
		load_addrs.push_back(addr);
	endtask

	task automatic dispatch(input op_type_t op, input word_t b, input word_t off,
			input logic off_rdy, input word_t sd, input logic sd_rdy,
			input rob_idx_t rob, input prf_tag_t tag);
		assert (!lsq_full) else fail_run("dispatch attempted while lsq_full was high");
		inst_valid = 1'b1;
		op_type = op;
		base = b;
		offset = off;
		offset_ready = off_rdy;
		store_data = sd;
		store_data_ready = sd_rdy;
		rob_idx = rob;
		dest_tag = tag;
		@(negedge clock);
		inst_valid = 1'b0;
	endtask

	task automatic broadcast(input prf_tag_t tag, input word_t value);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_value = value;
		@(negedge clock);
		cdb_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (open_results() != 0)
			@(negedge clock);
	endtask

	////////////////////////////////////////
	// Memory model, driven on the falling edge
	////////////////////////////////////////
	always @(negedge clock) begin
		int k;
		logic refuse;
		refuse = random_bits(mem_lfsr, 2) == 0;
		k = random_bits(mem_lfsr, 3);
		mem_tag = '0;
		mem_data_in = '0;
		mem_response = (reset || refuse) ? mem_tag_t'(0) : next_tag;
		if (!reset && !hold_fills && pend_tag.size() > 0) begin
			k = k % pend_tag.size();
			if (cycle >= pend_due[k]) begin  // Out of order return
				mem_tag = pend_tag[k];
				mem_data_in = pend_addr[k] ^ DATA_KEY;
				pend_tag.delete(k);
				pend_addr.delete(k);
				pend_due.delete(k);
			end
		end
	end

	// Bus and result monitor
	always @(posedge clock) begin
		int idx;
		cycle++;
		if (!reset) begin
			if (mem_command != BUS_NONE && mem_response != '0) begin
				if (mem_command == BUS_LOAD) begin
					assert (!store_pending)
						else fail_run("load sent to memory before an older store was written");
					idx = -1;
					foreach (load_addrs[i])
						if (load_addrs[i] == mem_address)
							idx = i;
					assert (idx >= 0)
						else fail_run($sformatf("mismatch mem_address %h is no expected load", mem_address));
					load_addrs.delete(idx);
					pend_tag.push_back(mem_response);
					pend_addr.push_back(mem_address);
					pend_due.push_back(cycle + 1 + random_bits(mem_lfsr, 3));
				end else begin
					assert (store_pending) else fail_run("store written to memory unexpectedly");
					assert (mem_address == store_addr_exp) else fail_run($sformatf(
						"mismatch mem_address %h expected %h", mem_address, store_addr_exp));
					assert (mem_data == store_data_exp) else fail_run($sformatf(
						"mismatch mem_data %h expected %h", mem_data, store_data_exp));
					assert (rob_head == store_rob_exp) else fail_run($sformatf(
						"mismatch rob_head %h expected %h", rob_head, store_rob_exp));
					store_pending = 1'b0;
				end
				do
					next_tag = next_tag + 1'b1;
				while (next_tag == '0 || tag_in_flight(next_tag));
			end
			if (result_valid) begin
				assert (exp_valid[result_tag])
					else fail_run($sformatf("result_valid for unexpected tag %h", result_tag));
				assert (result_value == exp_value[result_tag]) else fail_run($sformatf(
					"mismatch result_value %h expected %h", result_value, exp_value[result_tag]));
				assert (result_rob_idx == exp_rob[result_tag]) else fail_run($sformatf(
					"mismatch result_rob_idx %h expected %h", result_rob_idx, exp_rob[result_tag]));
				exp_valid[result_tag] = 1'b0;
			end
			if (mispredict) begin  // Flushed work expects nothing
				for (int i = 0; i < 64; i++)
					exp_valid[i] = 1'b0;
				load_addrs.delete();
				store_pending = 1'b0;
			end
		end
	end

	// A refused request is replayed unchanged
	property refused_request_held;
		@(posedge clock) disable iff (reset)
		(mem_command != BUS_NONE && mem_response == '0 && !mispredict)
			|=> ($stable(mem_command) && $stable(mem_address) && $stable(mem_data));
	endproperty
	assert property (refused_request_held)
		else fail_run("memory request changed while it was refused");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		fail_run("timeout, the watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// Directed sequence
	////////////////////////////////////////
	initial begin
		word_t b;
		word_t off;
		clock = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		op_type = '0;
		base = '0;
		offset = '0;
		offset_ready = 1'b0;
		store_data = '0;
		store_data_ready = 1'b0;
		rob_idx = '0;
		dest_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		rob_head = '0;
		mispredict = 1'b0;
		mem_response = '0;
		mem_tag = '0;
		mem_data_in = '0;
		mem_lfsr = 16'd18;
		stim_lfsr = 16'd18;
		cycle = 0;
		hold_fills = 1'b0;
		next_tag = 4'd1;
		store_pending = 1'b0;
		for (int i = 0; i < 64; i++)
			exp_valid[i] = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Idle after reset
		repeat (5) begin
			assert (!result_valid && mem_command == BUS_NONE && !lsq_full)
				else fail_run("outputs not idle after reset");
			@(negedge clock);
		end

		// Loads in flight, completing out of order
		for (int i = 0; i < 4; i++) begin
			b = 64'h1000 + 64'(i) * 64'h40 + 64'(random_bits(stim_lfsr, 8));
			off = 64'(random_bits(stim_lfsr, 8));
			expect_load(prf_tag_t'(10 + i), rob_idx_t'(i), b + off);
			dispatch(OP_LOAD, b, off, 1'b1, '0, 1'b0, rob_idx_t'(i), prf_tag_t'(10 + i));
		end
		wait_idle();

		// Offset waits on a tag from the result bus
		expect_load(6'd20, 5'd4, 64'h2000 + 64'h88);
		dispatch(OP_LOAD, 64'h2000, 64'(6'd33), 1'b0, '0, 1'b0, 5'd4, 6'd20);
		repeat (5) begin
			assert (mem_command == BUS_NONE)
				else fail_run("memory command before the offset tag was broadcast");
			@(negedge clock);
		end
		broadcast(6'd33, 64'h88);
		wait_idle();

		// Store with tagged operands reports, commits at ROB head, blocks a younger load
		store_pending = 1'b1;
		store_addr_exp = 64'h3000 + 64'h10;
		store_data_exp = 64'hdead_beef_0123_4567;
		store_rob_exp = 5'd5;
		dispatch(OP_STORE, 64'h3000, 64'(6'd34), 1'b0, 64'(6'd35), 1'b0, 5'd5, 6'd21);
		expect_load(6'd22, 5'd6, 64'h3400);
		dispatch(OP_LOAD, 64'h3400, 64'h0, 1'b1, '0, 1'b0, 5'd6, 6'd22);
		broadcast(6'd34, 64'h10);
		repeat (3) @(negedge clock);  // Data tag still pending, no report yet
		exp_valid[21] = 1'b1;
		exp_value[21] = 64'h3000 + 64'h10;
		exp_rob[21] = 5'd5;
		broadcast(6'd35, store_data_exp);
		while (exp_valid[21])
			@(negedge clock);
		repeat (5) begin
			assert (mem_command != BUS_STORE)
				else fail_run("store written before its ROB index reached the head");
			@(negedge clock);
		end
		rob_head = 5'd5;
		wait_idle();

		// Full queue, flush, and a late fill for a dropped tag
		hold_fills = 1'b1;
		for (int i = 0; i < LQ_SIZE; i++) begin
			expect_load(prf_tag_t'(40 + i), rob_idx_t'(8 + i), 64'h5000 + 64'(i) * 8);
			dispatch(OP_LOAD, 64'h5000, 64'(i) * 8, 1'b1, '0, 1'b0,
				rob_idx_t'(8 + i), prf_tag_t'(40 + i));
		end
		assert (lsq_full) else fail_run("lsq_full low with every load slot taken");
		repeat (10) @(negedge clock);
		mispredict = 1'b1;
		@(negedge clock);
		mispredict = 1'b0;
		assert (!lsq_full) else fail_run("lsq_full still high after the flush");
		hold_fills = 1'b0;
		while (pend_tag.size() != 0)
			@(negedge clock);
		repeat (5) @(negedge clock);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/lsq_pkg.sv
src/mem_bus_pkg.sv
src/lsq_dispatch_if.sv
src/mem_req_if.sv
src/load_queue.sv
src/store_queue.sv
src/mem_scheduler.sv
src/lsq.sv
bench/lsq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
